// File: list.f
+incdir+logic
logic/kbd_pkg.sv
logic/ps2_receiver.sv
logic/scancode_rom.sv
logic/seg7_decoder.sv
logic/keyboard_display.sv
sim/keyboard_display_tb.sv

// File: Bender.yml
package:
  name: keyboard_display

sources:
  - include_dirs:
      - logic
    files:
      - logic/kbd_pkg.sv
      - logic/ps2_receiver.sv
      - logic/scancode_rom.sv
      - logic/seg7_decoder.sv
      - logic/keyboard_display.sv
  - target: test
    include_dirs:
      - logic
    files:
      - sim/keyboard_display_tb.sv

// File: sim/keyboard_display_tb.sv
`timescale 1ns/1ps
`include "kbd_macros.svh"

module keyboard_display_tb;
    import kbd_pkg::*;

    localparam logic [31:0] SEED           = 32'h5f322122;
    localparam int          HALF_BIT       = 20;       // System clocks per PS/2 clock phase.
    localparam int          SETTLE_CYCLES  = 12;
    localparam int          RELEASE_TARGET = 105;
    localparam int          KEY_LIMIT      = 400;
    // Set-2 codes for a to z, then 0 to 9, then space.
    localparam logic [37*8-1:0] KEY_CODES = {
        8'h1C, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2B, 8'h34, 8'h33, 8'h43, 8'h3B,
        8'h42, 8'h4B, 8'h3A, 8'h31, 8'h44, 8'h4D, 8'h15, 8'h2D, 8'h1B, 8'h2C,
        8'h3C, 8'h2A, 8'h1D, 8'h22, 8'h35, 8'h1A,
        8'h45, 8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E, 8'h36, 8'h3D, 8'h3E, 8'h46,
        8'h29};
    localparam logic [4*8-1:0] OTHER_CODES = {8'h05, 8'h76, 8'h5A, 8'h66};  // F1, Esc, Enter, Bksp.
    // Lit segments per hex digit, g down to a, with digit F in the top slot.
    localparam logic [16*7-1:0] LIT_SEGS = {
        7'h71, 7'h79, 7'h5E, 7'h39, 7'h7C, 7'h77, 7'h6F, 7'h7F,
        7'h07, 7'h7D, 7'h6D, 7'h66, 7'h4F, 7'h5B, 7'h06, 7'h3F};

    logic        clk;
    logic        rst;
    logic        ps2_clk;
    logic        ps2_dat;
    display_t    display;
    logic [31:0] lfsr;
    scan_code_t  exp_key;
    logic        exp_blank;
    int          exp_count;
    int          releases;
    int          keystrokes;

    keyboard_display uut (
        .clk     (clk),
        .rst     (rst),
        .ps2_clk (ps2_clk),
        .ps2_dat (ps2_dat),
        .display (display)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ####################################################################
    // Random source and reference model
    // ####################################################################

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // Taps 32, 22, 2, 1.
    endfunction

    function automatic int random_bits(input int n);
        int r;
        r = 0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_next(lfsr);
            r    = (r << 1) | int'(lfsr[0]);
        end
        return r;
    endfunction

    function automatic scan_code_t table_code(input int i);
        return KEY_CODES[(36 - i)*8 +: 8];
    endfunction

    function automatic scan_code_t pick_code();
        if (random_bits(3) == 0)
            return OTHER_CODES[random_bits(2)*8 +: 8];
        return table_code(random_bits(6) % 37);
    endfunction

    function automatic ascii_t expected_ascii(input scan_code_t code);
        for (int i = 0; i < 37; i++)
        begin
            if (table_code(i) == code)
                return (i < 26) ? ascii_t'(8'h61 + i)
                     : (i < 36) ? ascii_t'(8'h30 + i - 26) : 8'h20;
        end
        return 8'h00;
    endfunction

    function automatic seg_t seg_of(input digit_t d, input logic blank);
        return blank ? 8'hFF : {1'b1, ~LIT_SEGS[d*7 +: 7]};
    endfunction

    function automatic display_t expected_display();
        display_t d;
        ascii_t   a;
        a          = expected_ascii(exp_key);
        d.key_hi   = seg_of(exp_key[7:4], exp_blank);
        d.key_lo   = seg_of(exp_key[3:0], exp_blank);
        d.ascii_hi = seg_of(a[7:4], exp_blank);
        d.ascii_lo = seg_of(a[3:0], exp_blank);
        d.count_hi = seg_of(digit_t'(exp_count / 10), 1'b0);
        d.count_lo = seg_of(digit_t'(exp_count % 10), 1'b0);
        return d;
    endfunction

    // ####################################################################
    // Checks and PS/2 driver
    // ####################################################################

    task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] want);
        if (got !== want)
        begin
            $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, name, got, want);
            $display("** FAIL **");
            $fatal(1, "display check failed");
        end
    endtask

    task automatic check_display();
        display_t e;
        e = expected_display();
        check_value("key_hi", display.key_hi, e.key_hi);
        check_value("key_lo", display.key_lo, e.key_lo);
        check_value("ascii_hi", display.ascii_hi, e.ascii_hi);
        check_value("ascii_lo", display.ascii_lo, e.ascii_lo);
        check_value("count_hi", display.count_hi, e.count_hi);
        check_value("count_lo", display.count_lo, e.count_lo);
    endtask

    // Polls until the display matches the model, giving up after limit cycles.
    task automatic wait_display(input int limit, output int used);
        used = 0;
        while (used < limit && display !== expected_display())
        begin
            @(negedge clk);
            used++;
        end
        check_display();
    endtask

    task automatic send_frame(input scan_code_t code, input logic bad_parity);
        logic [10:0] bits;
        int          used;
        bits = {1'b1, ~(^code) ^ bad_parity, code, 1'b0};  // Stop, odd parity, data, start.
        for (int i = 0; i < 11; i++)
        begin
            ps2_dat = bits[i];
            repeat (HALF_BIT) @(negedge clk);
            ps2_clk = 1'b0;
            used    = 0;
            if (i == 10)
                wait_display(SETTLE_CYCLES, used);        // Stop bit edge starts the window.
            repeat (HALF_BIT - used) @(negedge clk);
            ps2_clk = 1'b1;
        end
        ps2_dat = 1'b1;
        repeat (HALF_BIT) @(negedge clk);
        check_display();                                  // Still unchanged after the frame.
    endtask

    // ####################################################################
    // Keystroke sequence
    // ####################################################################

    initial
    begin
        scan_code_t code;
        int         repeats;
        rst        = 1'b0;
        ps2_clk    = 1'b1;
        ps2_dat    = 1'b1;
        lfsr       = SEED;
        exp_key    = '0;
        exp_blank  = 1'b1;
        exp_count  = 0;
        releases   = 0;
        keystrokes = 0;
        repeat (16) @(negedge clk);
        rst = 1'b1;
        repeat (4) @(negedge clk);
        check_display();
        while (releases < RELEASE_TARGET && keystrokes < KEY_LIMIT)
        begin
            keystrokes++;
            if (random_bits(3) == 0)
                send_frame(pick_code(), 1'b1);            // Dropped by the receiver.
            code      = pick_code();
            exp_key   = code;
            exp_blank = 1'b0;
            repeats   = 1 + random_bits(1);               // Auto-repeat sends the make again.
            repeat (repeats) send_frame(code, 1'b0);
            if (random_bits(1) == 1)
            begin
                send_frame(scan_code_t'(`KBD_BREAK_CODE), 1'b0);
                exp_blank = 1'b1;
                exp_count = (exp_count + 1) % `KBD_COUNT_WRAP;
                releases++;
                send_frame(code, 1'b0);
            end
        end
        if (releases == RELEASE_TARGET)
        begin
            check_value("count_hi", display.count_hi, seg_of(4'd0, 1'b0));
            check_value("count_lo", display.count_lo, seg_of(4'd5, 1'b0));
            $display("** PASS **");
            $finish;
        end
        else
        begin
            $display("Keystroke limit reached after only %0d releases.", releases);
            $display("** FAIL **");
            $fatal(1, "release target not reached");
        end
    end

endmodule

// File: logic/keyboard_display.sv
`timescale 1ns/1ps
`include "kbd_macros.svh"

module keyboard_display (
    input  logic              clk,
    input  logic              rst,
    input  logic              ps2_clk,
    input  logic              ps2_dat,
    output kbd_pkg::display_t display
);
    import kbd_pkg::*;

    localparam logic [6:0] COUNT_WRAP = 7'(`KBD_COUNT_WRAP);

    kbd_stream_t rx_stream;
    logic        nextdata_n;
    key_state_t  state;
    key_state_t  state_next;
    logic        start_event;
    logic        is_break;
    scan_code_t  key;
    ascii_t      ascii;
    logic        key_blank;
    logic [6:0]  count;
    digit_t      count_tens;
    digit_t      count_ones;

    ps2_receiver u_rx (
        .clk        (clk),
        .rst        (rst),
        .ps2_clk    (ps2_clk),
        .ps2_dat    (ps2_dat),
        .nextdata_n (nextdata_n),
        .stream     (rx_stream)
    );

    // ####################################################################
    // Key event FSM
    // ####################################################################

    assign start_event = rx_stream.ready && !rx_stream.overflow;
    assign is_break    = (rx_stream.data == scan_code_t'(`KBD_BREAK_CODE));

    always_comb
    begin
        state_next = state;
        case (state)
            IDLE:         if (start_event) state_next = is_break ? BREAK_PREFIX : MAKE;
            MAKE:         state_next = IDLE;
            BREAK_PREFIX: state_next = BREAK_WAIT;
            BREAK_WAIT:   if (rx_stream.ready) state_next = BREAK_POP;
            BREAK_POP:    state_next = IDLE;
            default:      state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
            state <= IDLE;
        else
            state <= state_next;
    end

    // Each consuming state removes the head it has just looked at.
    assign nextdata_n = !(state inside {MAKE, BREAK_PREFIX, BREAK_POP});

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            key       <= '0;
            key_blank <= 1'b1;
            count     <= '0;
        end
        else if (state == MAKE)
        begin
            key       <= rx_stream.data;
            key_blank <= 1'b0;
        end
        else if (state == BREAK_POP)
        begin
            key_blank <= 1'b1;
            count     <= (count == COUNT_WRAP - 7'd1) ? 7'd0 : count + 7'd1;
        end
    end

    // ####################################################################
    // Translation and display
    // ####################################################################

    scancode_rom u_rom (
        .clk  (clk),
        .rst  (rst),
        .addr (key),
        .data (ascii)
    );

    assign count_tens = digit_t'(count / 7'd10);
    assign count_ones = digit_t'(count % 7'd10);

    seg7_decoder u_key_hi   (.digit(key[7:4]),   .blank(key_blank), .seg(display.key_hi));
    seg7_decoder u_key_lo   (.digit(key[3:0]),   .blank(key_blank), .seg(display.key_lo));
    seg7_decoder u_ascii_hi (.digit(ascii[7:4]), .blank(key_blank), .seg(display.ascii_hi));
    seg7_decoder u_ascii_lo (.digit(ascii[3:0]), .blank(key_blank), .seg(display.ascii_lo));
    seg7_decoder u_count_hi (.digit(count_tens), .blank(1'b0),      .seg(display.count_hi));
    seg7_decoder u_count_lo (.digit(count_ones), .blank(1'b0),      .seg(display.count_lo));

    // The controller only pops what the receiver has announced.
    assert property (@(posedge clk) disable iff (!rst) !nextdata_n |-> rx_stream.ready)
        else $error("keyboard_display: pop without ready");

    assert property (@(posedge clk) disable iff (!rst) count < COUNT_WRAP)
        else $error("keyboard_display: release count out of range");

endmodule

// File: logic/seg7_decoder.sv
`timescale 1ns/1ps

module seg7_decoder (
    input  kbd_pkg::digit_t digit,
    input  logic            blank,
    output kbd_pkg::seg_t   seg
);

    logic [6:0] glyph;                 // Segments g down to a, active low.

    always_comb
    begin
        case (digit)
            4'h0:    glyph = 7'h40;
            4'h1:    glyph = 7'h79;
            4'h2:    glyph = 7'h24;
            4'h3:    glyph = 7'h30;
            4'h4:    glyph = 7'h19;
            4'h5:    glyph = 7'h12;
            4'h6:    glyph = 7'h02;
            4'h7:    glyph = 7'h78;
            4'h8:    glyph = 7'h00;
            4'h9:    glyph = 7'h10;
            4'hA:    glyph = 7'h08;
            4'hB:    glyph = 7'h03;    // Lower case b.
            4'hC:    glyph = 7'h46;
            4'hD:    glyph = 7'h21;    // Lower case d.
            4'hE:    glyph = 7'h06;
            default: glyph = 7'h0E;
        endcase
    end

    assign seg = blank ? 8'hFF : {1'b1, glyph};    // Decimal point stays dark.

endmodule

// File: logic/scancode_rom.sv
`timescale 1ns/1ps

module scancode_rom (
    input  logic                clk,
    input  logic                rst,
    input  kbd_pkg::scan_code_t addr,
    output kbd_pkg::ascii_t     data
);

    always_ff @(posedge clk)
    begin
        if (!rst)
            data <= 8'h00;
        else
        begin
            case (addr)
                8'h1C:   data <= 8'h61;    // a
                8'h32:   data <= 8'h62;
                8'h21:   data <= 8'h63;
                8'h23:   data <= 8'h64;
                8'h24:   data <= 8'h65;
                8'h2B:   data <= 8'h66;
                8'h34:   data <= 8'h67;
                8'h33:   data <= 8'h68;
                8'h43:   data <= 8'h69;
                8'h3B:   data <= 8'h6A;
                8'h42:   data <= 8'h6B;
                8'h4B:   data <= 8'h6C;
                8'h3A:   data <= 8'h6D;
                8'h31:   data <= 8'h6E;
                8'h44:   data <= 8'h6F;
                8'h4D:   data <= 8'h70;
                8'h15:   data <= 8'h71;
                8'h2D:   data <= 8'h72;
                8'h1B:   data <= 8'h73;
                8'h2C:   data <= 8'h74;
                8'h3C:   data <= 8'h75;
                8'h2A:   data <= 8'h76;
                8'h1D:   data <= 8'h77;
                8'h22:   data <= 8'h78;
                8'h35:   data <= 8'h79;
                8'h1A:   data <= 8'h7A;    // z
                8'h45:   data <= 8'h30;    // Digit row, 0 through 9.
                8'h16:   data <= 8'h31;
                8'h1E:   data <= 8'h32;
                8'h26:   data <= 8'h33;
                8'h25:   data <= 8'h34;
                8'h2E:   data <= 8'h35;
                8'h36:   data <= 8'h36;
                8'h3D:   data <= 8'h37;
                8'h3E:   data <= 8'h38;
                8'h46:   data <= 8'h39;
                8'h29:   data <= 8'h20;    // Space bar.
                default: data <= 8'h00;
            endcase
        end
    end

endmodule

// File: logic/ps2_receiver.sv
`timescale 1ns/1ps
`include "kbd_macros.svh"

module ps2_receiver #(
    parameter int fifo_depth = `KBD_FIFO_DEPTH
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 ps2_clk,
    input  logic                 ps2_dat,
    input  logic                 nextdata_n,
    output kbd_pkg::kbd_stream_t stream
);
    import kbd_pkg::*;

    localparam int SYNC  = `PS2_SYNC_STAGES;
    localparam int PTR_W = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
    localparam int CNT_W = $clog2(fifo_depth + 1);

    logic [SYNC-1:0]  clk_sync;
    logic [SYNC-1:0]  dat_sync;
    logic             clk_fall;
    logic             bit_in;
    logic [3:0]       bit_cnt;
    logic [9:0]       frame;
    logic             frame_done;
    logic             frame_good;
    scan_code_t       mem [fifo_depth];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             push;
    logic             pop;
    logic             overflow;

    // ####################################################################
    // Line synchronizers and frame assembly
    // ####################################################################

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            clk_sync <= '1;                            // Both lines idle high.
            dat_sync <= '1;
        end
        else
        begin
            clk_sync <= {clk_sync[SYNC-2:0], ps2_clk};
            dat_sync <= {dat_sync[SYNC-2:0], ps2_dat};
        end
    end

    assign clk_fall = clk_sync[SYNC-1] & ~clk_sync[SYNC-2];
    assign bit_in   = dat_sync[SYNC-2];                // Same age as the edge seen.

    always_ff @(posedge clk)
    begin
        if (!rst)
            bit_cnt <= '0;
        else if (clk_fall)
            bit_cnt <= (bit_cnt == 4'd10) ? 4'd0 : bit_cnt + 4'd1;
    end

    always_ff @(posedge clk)
    begin
        if (clk_fall && bit_cnt != 4'd10)
            frame[bit_cnt] <= bit_in;                  // Start, data LSB first, parity.
    end

    assign frame_done = clk_fall && (bit_cnt == 4'd10);
    // Start low, stop high, and an odd number of ones over data and parity.
    assign frame_good = frame_done && !frame[0] && bit_in && (^frame[9:1]);

    // ####################################################################
    // Byte FIFO
    // ####################################################################

    assign full = (count == CNT_W'(fifo_depth));
    assign push = frame_good && !full;
    assign pop  = !nextdata_n && (count != '0);

    always_ff @(posedge clk)
    begin
        if (push)
            mem[wr_ptr] <= frame[8:1];
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end
        else
        begin
            if (push)
                wr_ptr <= (wr_ptr == PTR_W'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_W'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            if (frame_good && full)
                overflow <= 1'b1;                      // Sticky until reset.
        end
    end

    assign stream.ready    = (count != '0);
    assign stream.overflow = overflow;
    assign stream.data     = mem[rd_ptr];

    // The consumer must never pop an empty queue.
    assert property (@(posedge clk) disable iff (!rst) !nextdata_n |-> count != '0)
        else $error("ps2_receiver: pop while FIFO empty");

    assert property (@(posedge clk) disable iff (!rst) count <= CNT_W'(fifo_depth))
        else $error("ps2_receiver: FIFO count above depth");

endmodule

// File: logic/kbd_pkg.sv
package kbd_pkg;

    typedef logic [7:0] scan_code_t;   // One byte from the keyboard.
    typedef logic [7:0] ascii_t;
    typedef logic [3:0] digit_t;       // One hex or decimal display digit.

    // Bit 0 is segment a up to bit 6 for segment g, bit 7 is the decimal point.
    // All lines are active low.
    typedef logic [7:0] seg_t;

    typedef struct packed {
        logic       ready;             // FIFO holds at least one byte.
        logic       overflow;          // A good byte was lost since reset.
        scan_code_t data;              // Head of the FIFO.
    } kbd_stream_t;

    typedef struct packed {
        seg_t key_hi;
        seg_t key_lo;
        seg_t ascii_hi;
        seg_t ascii_lo;
        seg_t count_hi;
        seg_t count_lo;
    } display_t;

    typedef enum logic [2:0] {
        IDLE,
        MAKE,
        BREAK_PREFIX,
        BREAK_WAIT,
        BREAK_POP
    } key_state_t;

endpackage

// File: logic/kbd_macros.svh
`ifndef KBD_MACROS_SVH
`define KBD_MACROS_SVH

// ####################################################################
// Receiver sizing
// ####################################################################

`define KBD_FIFO_DEPTH 8           // Bytes held between receiver and controller.
`define PS2_SYNC_STAGES 3          // Flops on each PS/2 line before use.

// ####################################################################
// Key event decoding
// ####################################################################

`define KBD_BREAK_CODE 8'hF0       // Prefix that marks a key release.
`define KBD_COUNT_WRAP 100         // Release count runs 0 to 99.

`endif
